// ==== logic/eth_frame_router.sv ====
/* receive Ethernet frame router behind a gigabit MAC, steering IPv4 and ARP payloads
   into their own packet queues; any overflow flag needs a reset to clear */
`timescale 1ns/1ps
`include "rx_router_defs.svh"

module eth_frame_router (
    input  logic                    i_rxmac_clk,
    input  logic                    i_rxmac_srst,
    input  logic                    i_rx_write,
    input  logic                    i_rx_eof,
    input  logic                    i_rx_error,
    input  rx_router_pkg::rx_byte_t i_rx_dbout,
    input  rx_router_pkg::rx_stat_t i_rx_stat_vector,
    output rx_router_pkg::rx_byte_t o_ipv4_pkt_byte,
    output logic                    o_ipv4_pkt_byte_vld,
    output logic                    o_ipv4_pkt_last_byte,
    input  logic                    i_ipv4_pkt_byte_rd,
    output rx_router_pkg::rx_byte_t o_arp_pkt_byte,
    output logic                    o_arp_pkt_byte_vld,
    output logic                    o_arp_pkt_last_byte,
    input  logic                    i_arp_pkt_byte_rd,
    output logic                    o_eth_frame_circ_buf_overflow,
    output logic                    o_ipv4_pkt_fifo_overflow,
    output logic                    o_arp_pkt_fifo_overflow,
    output logic                    o_eth_frame_long_frame_error,  // one-cycle pulses from here on
    output logic                    o_eth_frame_short_frame_error,
    output logic                    o_eth_frame_crc_error,
    output logic                    o_unsupported_eth_type_error
);
    import rx_router_pkg::*;

    logic       wr_en;
    cbuf_addr_t wr_addr;
    cbuf_word_t wr_word;
    cbuf_addr_t head;
    cbuf_addr_t rd_addr;
    cbuf_addr_t tail;
    cbuf_word_t rd_word;
    logic       ipv4_wr;
    logic       arp_wr;
    cbuf_word_t ipv4_word;
    cbuf_word_t arp_word;
    logic       ipv4_afull;
    logic       arp_afull;
    logic       fatal_hold;

    // any lost byte leaves the pointers untrustworthy, so park both state machines
    assign fatal_hold = o_eth_frame_circ_buf_overflow | o_ipv4_pkt_fifo_overflow |
                        o_arp_pkt_fifo_overflow;

    frame_capture capture (
        .i_rxmac_clk, .i_rxmac_srst, .i_hold(fatal_hold),
        .i_rx_write, .i_rx_eof, .i_rx_error, .i_rx_dbout, .i_rx_stat_vector,
        .o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_word(wr_word), .o_head(head),
        .o_long_frame_error(o_eth_frame_long_frame_error),
        .o_short_frame_error(o_eth_frame_short_frame_error),
        .o_crc_error(o_eth_frame_crc_error)
    );

    frame_store store (
        .i_rxmac_clk, .i_rxmac_srst,
        .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_word(wr_word), .i_head(head),
        .i_rd_addr(rd_addr), .i_tail(tail),
        .o_rd_word(rd_word), .o_overflow(o_eth_frame_circ_buf_overflow)
    );

    ethtype_dispatch dispatch (
        .i_rxmac_clk, .i_rxmac_srst, .i_hold(fatal_hold),
        .i_head(head), .i_rd_word(rd_word), .i_ipv4_afull(ipv4_afull), .i_arp_afull(arp_afull),
        .o_rd_addr(rd_addr), .o_tail(tail),
        .o_ipv4_wr(ipv4_wr), .o_ipv4_word(ipv4_word), .o_arp_wr(arp_wr), .o_arp_word(arp_word),
        .o_unsupported_ethtype(o_unsupported_eth_type_error)
    );

    // IPv4 keeps room for a full MTU payload
    pkt_queue #(.ADDR_BITS(`IPV4_Q_ADDR_BITS), .AFULL_ROOM(`ETH_MTU_BYTES)) ipv4_queue (
        .i_rxmac_clk, .i_rxmac_srst, .i_wr(ipv4_wr), .i_word(ipv4_word),
        .i_rd(i_ipv4_pkt_byte_rd), .o_byte(o_ipv4_pkt_byte), .o_last(o_ipv4_pkt_last_byte),
        .o_vld(o_ipv4_pkt_byte_vld), .o_afull(ipv4_afull), .o_overflow(o_ipv4_pkt_fifo_overflow)
    );

    // ARP frames are small, a minimum frame's worth of room is enough
    pkt_queue #(.ADDR_BITS(`ARP_Q_ADDR_BITS), .AFULL_ROOM(`ETH_MIN_FRAME_BYTES)) arp_queue (
        .i_rxmac_clk, .i_rxmac_srst, .i_wr(arp_wr), .i_word(arp_word),
        .i_rd(i_arp_pkt_byte_rd), .o_byte(o_arp_pkt_byte), .o_last(o_arp_pkt_last_byte),
        .o_vld(o_arp_pkt_byte_vld), .o_afull(arp_afull), .o_overflow(o_arp_pkt_fifo_overflow)
    );

endmodule

// ==== logic/ethtype_dispatch.sv ====
/* read side of the router: pulls committed frames out of the store, checks the EtherType
   and copies the payload into the IPv4 or ARP queue, or skips the frame */
`timescale 1ns/1ps
`include "rx_router_defs.svh"

module ethtype_dispatch (
    input  logic                      i_rxmac_clk,
    input  logic                      i_rxmac_srst,
    input  logic                      i_hold,
    input  rx_router_pkg::cbuf_addr_t i_head,
    input  rx_router_pkg::cbuf_word_t i_rd_word,
    input  logic                      i_ipv4_afull,
    input  logic                      i_arp_afull,
    output rx_router_pkg::cbuf_addr_t o_rd_addr,
    output rx_router_pkg::cbuf_addr_t o_tail,     // next byte to read, trails the head
    output logic                      o_ipv4_wr,
    output rx_router_pkg::cbuf_word_t o_ipv4_word,
    output logic                      o_arp_wr,
    output rx_router_pkg::cbuf_word_t o_arp_word,
    output logic                      o_unsupported_ethtype
);
    import rx_router_pkg::*;

    disp_state_t state;
    ethtype_t    ethtype;
    logic        rd_eof;  // byte on the read port closes the frame
    logic        rd_step; // move the read address to the tail and bump the tail

    assign rd_eof = i_rd_word[$bits(cbuf_word_t)-1];

    always_comb begin
        case (state)
            DISP_IDLE:       rd_step = (o_tail != i_head);
            DISP_ETH_HI:     rd_step = 1'b1;
            DISP_CHECK: begin
                if (ethtype == `ETHTYPE_ARP)       rd_step = !i_arp_afull;
                else if (ethtype == `ETHTYPE_IPV4) rd_step = !i_ipv4_afull;
                else                               rd_step = 1'b1; // start skipping at once
            end
            DISP_WAIT_ARP:   rd_step = !i_arp_afull;
            DISP_WAIT_IPV4:  rd_step = !i_ipv4_afull;
            DISP_ROUTE_ARP, DISP_ROUTE_IPV4, DISP_SKIP: rd_step = !rd_eof;
            default:         rd_step = 1'b0; // the second EtherType byte is already on the port
        endcase
    end

    always_ff @(posedge i_rxmac_clk) begin
        if (i_rxmac_srst || i_hold) begin
            state                 <= DISP_IDLE;
            o_rd_addr             <= '0;
            o_tail                <= '0;
            o_ipv4_wr             <= 1'b0;
            o_arp_wr              <= 1'b0;
            o_unsupported_ethtype <= 1'b0;
        end else begin
            o_ipv4_wr             <= (state == DISP_ROUTE_IPV4);
            o_arp_wr              <= (state == DISP_ROUTE_ARP);
            o_unsupported_ethtype <= 1'b0;
            if (rd_step) begin
                o_rd_addr <= o_tail;
                o_tail    <= o_tail + 1'b1;
            end
            case (state)
                DISP_IDLE:   if (o_tail != i_head) state <= DISP_ETH_HI;
                DISP_ETH_HI: state <= DISP_ETH_LO;
                DISP_ETH_LO: state <= DISP_CHECK;
                DISP_CHECK: begin
                    if (ethtype == `ETHTYPE_ARP) begin
                        state <= i_arp_afull ? DISP_WAIT_ARP : DISP_ROUTE_ARP;
                    end else if (ethtype == `ETHTYPE_IPV4) begin
                        state <= i_ipv4_afull ? DISP_WAIT_IPV4 : DISP_ROUTE_IPV4;
                    end else begin
                        o_unsupported_ethtype <= 1'b1;
                        state                 <= DISP_SKIP;
                    end
                end
                DISP_WAIT_ARP:   if (!i_arp_afull) state <= DISP_ROUTE_ARP;
                DISP_WAIT_IPV4:  if (!i_ipv4_afull) state <= DISP_ROUTE_IPV4;
                // the whole frame is committed so routing never stalls
                DISP_ROUTE_ARP, DISP_ROUTE_IPV4, DISP_SKIP: begin
                    if (rd_eof) state <= DISP_IDLE;
                end
                default: state <= DISP_IDLE;
            endcase
        end
    end

    // EtherType bytes and queue data, qualified by state and the write strobes
    always_ff @(posedge i_rxmac_clk) begin
        if (state == DISP_ETH_HI) ethtype[15:8] <= i_rd_word[7:0];
        if (state == DISP_ETH_LO) ethtype[7:0]  <= i_rd_word[7:0];
        if (state == DISP_ROUTE_IPV4) o_ipv4_word <= i_rd_word;
        if (state == DISP_ROUTE_ARP)  o_arp_word  <= i_rd_word;
    end

endmodule

// ==== logic/frame_capture.sv ====
/* MAC side of the router: drops the address bytes and writes the rest of each frame into
   the frame store, committing the head pointer only for frames that end clean */
`timescale 1ns/1ps
`include "rx_router_defs.svh"

module frame_capture (
    input  logic                     i_rxmac_clk,
    input  logic                     i_rxmac_srst,
    input  logic                     i_hold,           // sticky overflow somewhere, sit in reset
    input  logic                     i_rx_write,
    input  logic                     i_rx_eof,
    input  logic                     i_rx_error,
    input  rx_router_pkg::rx_byte_t  i_rx_dbout,
    input  rx_router_pkg::rx_stat_t  i_rx_stat_vector,
    output logic                     o_wr_en,
    output rx_router_pkg::cbuf_addr_t o_wr_addr,
    output rx_router_pkg::cbuf_word_t o_wr_word,
    output rx_router_pkg::cbuf_addr_t o_head,          // first free byte after the last good frame
    output logic                     o_long_frame_error,
    output logic                     o_short_frame_error,
    output logic                     o_crc_error
);
    import rx_router_pkg::*;

    localparam int CNT_BITS = $clog2(`MAC_ADDR_BYTES);
    localparam logic [CNT_BITS-1:0] LAST_ADDR_CNT = CNT_BITS'(`MAC_ADDR_BYTES - 1);

    cap_state_t          state;
    logic [CNT_BITS-1:0] addr_cnt;   // address bytes seen so far in this frame
    cbuf_addr_t          next_addr;  // where the next stored byte lands, runs ahead of the head
    logic                store_byte;
    logic                frame_bad;

    assign store_byte = i_rx_write && (state == CAP_STORE);
    // eof qualifies both the error line and the status vector
    assign frame_bad  = i_rx_error || ((i_rx_stat_vector & `RXSTAT_DISCARD_MASK) != '0);

    always_ff @(posedge i_rxmac_clk) begin
        if (i_rxmac_srst || i_hold) begin
            state               <= CAP_IDLE;
            addr_cnt            <= '0;
            next_addr           <= '0;
            o_head              <= '0;
            o_wr_en             <= 1'b0;
            o_long_frame_error  <= 1'b0;
            o_short_frame_error <= 1'b0;
            o_crc_error         <= 1'b0;
        end else begin
            o_wr_en             <= store_byte; // one store write per MAC byte past the addresses
            o_long_frame_error  <= 1'b0;
            o_short_frame_error <= 1'b0;
            o_crc_error         <= 1'b0;
            case (state)
                CAP_IDLE: begin
                    if (i_rx_write) begin // first destination address byte
                        addr_cnt <= CNT_BITS'(1);
                        state    <= CAP_SKIP_ADDR;
                    end
                end
                CAP_SKIP_ADDR: begin
                    if (i_rx_write) begin
                        addr_cnt <= addr_cnt + 1'b1;
                        if (addr_cnt == LAST_ADDR_CNT) state <= CAP_STORE;
                    end
                end
                default: begin
                    if (store_byte) begin
                        next_addr <= next_addr + 1'b1;
                        if (i_rx_eof) begin
                            state <= CAP_IDLE;
                            if (frame_bad) begin
                                next_addr           <= o_head; // roll back, the frame never happened
                                o_long_frame_error  <= i_rx_stat_vector[`RXSTAT_LONG_BIT];
                                o_short_frame_error <= i_rx_stat_vector[`RXSTAT_SHORT_BIT];
                                o_crc_error         <= i_rx_stat_vector[`RXSTAT_CRC_BIT];
                            end else begin
                                o_head <= next_addr + 1'b1; // commit, dispatch may start now
                            end
                        end
                    end
                end
            endcase
        end
    end

    // write address and data only matter while o_wr_en is high
    always_ff @(posedge i_rxmac_clk) begin
        if (store_byte) begin
            o_wr_addr <= next_addr;
            o_wr_word <= {i_rx_eof, i_rx_dbout};
        end
    end

endmodule

// ==== logic/frame_store.sv ====
/* circular byte store between capture and dispatch, holding committed frames with their
   end-of-frame bits; written on the clock and read combinationally */
`timescale 1ns/1ps
`include "rx_router_defs.svh"

module frame_store (
    input  logic                      i_rxmac_clk,
    input  logic                      i_rxmac_srst,
    input  logic                      i_wr_en,
    input  rx_router_pkg::cbuf_addr_t i_wr_addr,
    input  rx_router_pkg::cbuf_word_t i_wr_word,
    input  rx_router_pkg::cbuf_addr_t i_head,
    input  rx_router_pkg::cbuf_addr_t i_rd_addr,
    input  rx_router_pkg::cbuf_addr_t i_tail,
    output rx_router_pkg::cbuf_word_t o_rd_word,
    output logic                      o_overflow  // sticky until reset
);
    import rx_router_pkg::*;

    cbuf_word_t mem [2**`CBUF_ADDR_BITS];
    logic       empty; // nothing committed is waiting to be read

    always_ff @(posedge i_rxmac_clk) begin
        if (i_wr_en) mem[i_wr_addr] <= i_wr_word;
    end

    assign o_rd_word = mem[i_rd_addr]; // dispatch needs the byte in the same cycle

    always_ff @(posedge i_rxmac_clk) begin
        if (i_rxmac_srst) begin
            empty      <= 1'b1;
            o_overflow <= 1'b0;
        end else begin
            empty <= (i_tail == i_head);
            // capture has wrapped onto data dispatch has not finished with
            if (i_wr_en && (i_wr_addr == i_rd_addr) && !empty) begin
                o_overflow <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/pkt_queue.sv ====
/* first-word-fall-through byte queue with a last-byte flag, used once for IPv4 and once
   for ARP; almost-full keeps room for one whole packet */
`timescale 1ns/1ps

module pkt_queue #(
    parameter int ADDR_BITS  = 7,
    parameter int AFULL_ROOM = 64  // free entries needed before almost-full drops
) (
    input  logic       i_rxmac_clk,
    input  logic       i_rxmac_srst,
    input  logic       i_wr,
    input  logic [8:0] i_word,     // last flag on top of the byte
    input  logic       i_rd,
    output logic [7:0] o_byte,
    output logic       o_last,
    output logic       o_vld,
    output logic       o_afull,
    output logic       o_overflow  // sticky, a write was dropped
);
    localparam logic [ADDR_BITS:0] DEPTH = (ADDR_BITS+1)'(2**ADDR_BITS);
    localparam logic [ADDR_BITS:0] ROOM  = (ADDR_BITS+1)'(AFULL_ROOM);

    logic [8:0]           mem [2**ADDR_BITS];
    logic [ADDR_BITS-1:0] wr_ptr;
    logic [ADDR_BITS-1:0] rd_ptr;
    logic [ADDR_BITS:0]   count;   // one bit wider so full and empty differ
    logic                 full;
    logic                 push;
    logic                 pop;

    assign full    = (count == DEPTH);
    assign push    = i_wr && !full;
    assign pop     = i_rd && o_vld;   // a strobe on an empty queue does nothing
    assign o_vld   = (count != '0);
    assign o_afull = ((DEPTH - count) < ROOM);
    assign {o_last, o_byte} = mem[rd_ptr]; // head word shows without a read

    always_ff @(posedge i_rxmac_clk) begin
        if (push) mem[wr_ptr] <= i_word;
    end

    always_ff @(posedge i_rxmac_clk) begin
        if (i_rxmac_srst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            o_overflow <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + (ADDR_BITS+1)'(push) - (ADDR_BITS+1)'(pop);
            if (i_wr && full) o_overflow <= 1'b1;
        end
    end

endmodule

// ==== logic/rx_router_defs.svh ====
/* constants shared by the receive frame router: frame layout, status bits and buffer sizes
   include this wherever a field position, EtherType or depth is needed */
`ifndef RX_ROUTER_DEFS_SVH
`define RX_ROUTER_DEFS_SVH

`define MAC_ADDR_BYTES       12          // destination plus source address, dropped by capture
`define ETH_MTU_BYTES        1500        // biggest IPv4 payload we ever route
`define ETH_MIN_FRAME_BYTES  64          // room kept free in the ARP queue before a frame starts

`define ETHTYPE_IPV4         16'h0800
`define ETHTYPE_ARP          16'h0806

`define CBUF_ADDR_BITS       14          // six full frames rounded up to a power of two
`define IPV4_Q_ADDR_BITS     13
`define ARP_Q_ADDR_BITS      7

// MAC status vector bits that get their own error pulse
`define RXSTAT_LONG_BIT      31
`define RXSTAT_SHORT_BIT     30
`define RXSTAT_CRC_BIT       25
`define RXSTAT_DISCARD_MASK  32'hC75F_0000 // bits 31, 30, 26-24, 22 and 20-16 drop the frame

`endif

// ==== logic/rx_router_pkg.sv ====
/* types used across the receive frame router stages
   compile this before any of the router modules */
`include "rx_router_defs.svh"

package rx_router_pkg;

    typedef logic [7:0]                 rx_byte_t;   // one byte as it comes out of the MAC
    typedef logic [8:0]                 cbuf_word_t; // end-of-frame bit on top of the byte
    typedef logic [`CBUF_ADDR_BITS-1:0] cbuf_addr_t;
    typedef logic [15:0]                ethtype_t;
    typedef logic [31:0]                rx_stat_t;   // status vector, qualified by eof

    // capture side, MAC to frame store
    typedef enum logic [1:0] {CAP_IDLE, CAP_SKIP_ADDR, CAP_STORE} cap_state_t;

    // read side, frame store to the packet queues
    typedef enum logic [3:0] {
        DISP_IDLE, DISP_ETH_HI, DISP_ETH_LO, DISP_CHECK,
        DISP_WAIT_ARP, DISP_ROUTE_ARP, DISP_WAIT_IPV4, DISP_ROUTE_IPV4, DISP_SKIP
    } disp_state_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# builds the router testbench with Verilator, runs it from the project root and
# passes only when the simulation output holds the pass line
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps -f vlog.f \
    --top-module eth_frame_router_tb -o router_sim \
    && ./obj_dir/router_sim | tee /dev/stderr | grep -q -F '*** TEST PASSED ***' \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

// ==== tests/eth_frame_router_tb.sv ====
/* self-checking testbench for the receive frame router that plays MAC bytes from the data file,
   pops both packet queues at random and checks words, error pulse counts and overflow flags */
`timescale 1ns/1ps

module eth_frame_router_tb;
    import rx_router_pkg::*;

    localparam int MAX_RECS = 512;

    logic       i_rxmac_clk;
    logic       i_rxmac_srst;
    logic       i_rx_write;
    logic       i_rx_eof;
    logic       i_rx_error;
    rx_byte_t   i_rx_dbout;
    rx_stat_t   i_rx_stat_vector;
    rx_byte_t   o_ipv4_pkt_byte;
    logic       o_ipv4_pkt_byte_vld;
    logic       o_ipv4_pkt_last_byte;
    logic       i_ipv4_pkt_byte_rd;
    rx_byte_t   o_arp_pkt_byte;
    logic       o_arp_pkt_byte_vld;
    logic       o_arp_pkt_last_byte;
    logic       i_arp_pkt_byte_rd;
    logic       o_eth_frame_circ_buf_overflow;
    logic       o_ipv4_pkt_fifo_overflow;
    logic       o_arp_pkt_fifo_overflow;
    logic       o_eth_frame_long_frame_error;
    logic       o_eth_frame_short_frame_error;
    logic       o_eth_frame_crc_error;
    logic       o_unsupported_eth_type_error;

    logic [47:0] file_recs [0:MAX_RECS-1]; // raw hex records with the kind in the low nibble
    logic [47:0] mac_recs [$];
    cbuf_word_t  exp_ipv4 [$];              // {last, byte} in the order the queue must give them
    cbuf_word_t  exp_arp [$];
    int          ipv4_idx = 0;
    int          arp_idx = 0;
    int          exp_long, exp_short, exp_crc, exp_unsup;
    int          long_cnt = 0, short_cnt = 0, crc_cnt = 0, unsup_cnt = 0;
    int          mismatches = 0;
    int          other_errors = 0;
    bit          have_counts = 1'b0;
    bit          loaded = 1'b0;
    integer      seed = 32'hd835_69cb;

    eth_frame_router dut (.*);

    initial begin
        i_rxmac_clk = 1'b0;
        forever #2 i_rxmac_clk = ~i_rxmac_clk; // 250 MHz
    end

    task automatic load_records();
        logic [47:0] rec;
        bit          done;
        done = 1'b0;
        $readmemh("tests/router_tests.txt", file_recs);
        for (int i = 0; i < MAX_RECS && !done; i++) begin
            rec = file_recs[i];
            case (rec[3:0])
                4'h1: mac_recs.push_back(rec);
                4'h2: exp_ipv4.push_back(rec[12:4]);  // last flag sits just above the byte
                4'h3: exp_arp.push_back(rec[12:4]);
                4'h4: begin
                    exp_long    = int'(rec[35:28]);
                    exp_short   = int'(rec[27:20]);
                    exp_crc     = int'(rec[19:12]);
                    exp_unsup   = int'(rec[11:4]);
                    have_counts = 1'b1;
                end
                4'hf: done = 1'b1;
                default: begin
                    other_errors++;
                    $display("ERROR: record %0d of the data file has an unknown kind", i);
                    done = 1'b1;
                end
            endcase
        end
        if (!have_counts) begin
            other_errors++;
            $display("ERROR: the data file holds no pulse count record");
        end
    endtask

    // record layout is status[47:16], error/eof/write in [14:12], byte in [11:4]
    task automatic drive_mac(input logic [47:0] rec);
        i_rx_write       <= rec[12];
        i_rx_eof         <= rec[13];
        i_rx_error       <= rec[14];
        i_rx_dbout       <= rec[11:4];
        i_rx_stat_vector <= rec[47:16];
    endtask

    task automatic check_word(input string name, input logic got_last, input rx_byte_t got_byte,
                              input cbuf_word_t exp);
        if ({got_last, got_byte} !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name,
                     {got_last, got_byte}, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s pulses got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // both read strobes are drawn here in a fixed order and are high about 3 cycles in 4
    always @(posedge i_rxmac_clk) begin
        i_ipv4_pkt_byte_rd <= !i_rxmac_srst && (($random(seed) & 3) != 0);
        i_arp_pkt_byte_rd  <= !i_rxmac_srst && (($random(seed) & 3) != 0);
    end

    // each queue reader pops whenever its strobe meets valid
    always @(posedge i_rxmac_clk) begin
        if (i_ipv4_pkt_byte_rd && o_ipv4_pkt_byte_vld) begin
            if (ipv4_idx < exp_ipv4.size()) begin
                check_word("o_ipv4_pkt_last_byte/o_ipv4_pkt_byte", o_ipv4_pkt_last_byte,
                           o_ipv4_pkt_byte, exp_ipv4[ipv4_idx]);
            end else begin
                other_errors++;
                $display("ERROR at %0t: IPv4 queue gave a word beyond the expected ones", $time);
            end
            ipv4_idx++;
        end
    end

    always @(posedge i_rxmac_clk) begin
        if (i_arp_pkt_byte_rd && o_arp_pkt_byte_vld) begin
            if (arp_idx < exp_arp.size()) begin
                check_word("o_arp_pkt_last_byte/o_arp_pkt_byte", o_arp_pkt_last_byte,
                           o_arp_pkt_byte, exp_arp[arp_idx]);
            end else begin
                other_errors++;
                $display("ERROR at %0t: ARP queue gave a word beyond the expected ones", $time);
            end
            arp_idx++;
        end
    end

    always @(posedge i_rxmac_clk) begin
        if (!i_rxmac_srst) begin // pulses are one cycle wide so each high sample is one event
            long_cnt  <= long_cnt + int'(o_eth_frame_long_frame_error);
            short_cnt <= short_cnt + int'(o_eth_frame_short_frame_error);
            crc_cnt   <= crc_cnt + int'(o_eth_frame_crc_error);
            unsup_cnt <= unsup_cnt + int'(o_unsupported_eth_type_error);
        end
    end

    initial begin
        wait (loaded);
        repeat (50 * mac_recs.size() + 2000) @(posedge i_rxmac_clk);
        $display("ERROR: watchdog expired with IPv4 %0d of %0d and ARP %0d of %0d words seen",
                 ipv4_idx, exp_ipv4.size(), arp_idx, exp_arp.size());
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors + 1);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        i_rxmac_srst       = 1'b1;
        i_rx_write         = 1'b0;
        i_rx_eof           = 1'b0;
        i_rx_error         = 1'b0;
        i_rx_dbout         = '0;
        i_rx_stat_vector   = '0;
        i_ipv4_pkt_byte_rd = 1'b0;
        i_arp_pkt_byte_rd  = 1'b0;
        load_records();
        loaded = 1'b1;
        repeat (4) @(posedge i_rxmac_clk);
        i_rxmac_srst <= 1'b0;
        foreach (mac_recs[k]) begin
            @(posedge i_rxmac_clk);
            drive_mac(mac_recs[k]);
        end
        @(posedge i_rxmac_clk);
        drive_mac(48'h1);                 // MAC goes quiet
        while (ipv4_idx < exp_ipv4.size() || arp_idx < exp_arp.size()) @(posedge i_rxmac_clk);
        repeat (200) @(posedge i_rxmac_clk); // stray words or late pulses would land here
        check_count("o_eth_frame_long_frame_error", long_cnt, exp_long);
        check_count("o_eth_frame_short_frame_error", short_cnt, exp_short);
        check_count("o_eth_frame_crc_error", crc_cnt, exp_crc);
        check_count("o_unsupported_eth_type_error", unsup_cnt, exp_unsup);
        // the flags are sticky so low now means low for the whole run
        check_flag("o_eth_frame_circ_buf_overflow", o_eth_frame_circ_buf_overflow, 1'b0);
        check_flag("o_ipv4_pkt_fifo_overflow", o_ipv4_pkt_fifo_overflow, 1'b0);
        check_flag("o_arp_pkt_fifo_overflow", o_arp_pkt_fifo_overflow, 1'b0);
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tests/router_tests.txt ====
// hex records, kind in the low digit: 1 MAC byte SSSSSSSS F BB, F = error/eof/write bits
// 2 and 3 expected IPv4 and ARP words L BB, 4 pulse counts LL SS CC UU, f ends the file
// ipv4 frame, addresses then EtherType 0800 and eight payload bytes
1021 1001 1001 1001 1001 1011 1021 1001 1001 1001 1001 1021
1081 1001 1451 1001 1001 11c1 1111 1221 1331 3441
0452 0002 0002 01c2 0112 0222 0332 1442
// arp frame with EtherType 0806, then two idle cycles
1021 1001 1001 1001 1001 1011 1021 1001 1001 1001 1001 1021
1081 1061 1001 1011 1081 1001 1061 1041 1001 3011 0001 0001
0003 0013 0083 0003 0063 0043 0003 1013
// crc error in the status vector, nothing queued
1021 1001 1001 1001 1001 1011 1021 1001 1001 1001 1001 1021 1081 1001 1aa1 1bb1 020000003cc1
// good ipv4 frame right after the bad one
1021 1001 1001 1001 1001 1011 1021 1001 1001 1001 1001 1021 1081 1001 1de1 1ad1 1be1 3ef1
0de2 0ad2 0be2 1ef2
// long frame then short frame, both dropped
1021 1001 1001 1001 1001 1011 1021 1001 1001 1001 1001 1021 1081 1061 1011 800000003021
1021 1001 1001 1001 1001 1011 1021 1001 1001 1001 1001 1021 1081 1001 1551 400000003661
// MAC error line with a clean status vector drops the frame without a pulse
1021 1001 1001 1001 1001 1011 1021 1001 1001 1001 1001 1021 1081 1001 1771 7881
// ipv6 EtherType 86dd is skipped
1021 1001 1001 1001 1001 1011 1021 1001 1001 1001 1001 1021 1861 1dd1 1601 1001 1001 3001
// arp frame after the skipped one
1021 1001 1001 1001 1001 1011 1021 1001 1001 1001 1001 1021 1081 1061 1001 1021 1c01 3a81
0003 0023 0c03 1a83
010101014
f

// ==== vlog.f ====
+incdir+logic
logic/rx_router_pkg.sv
logic/pkt_queue.sv
logic/frame_capture.sv
logic/frame_store.sv
logic/ethtype_dispatch.sv
logic/eth_frame_router.sv
tests/eth_frame_router_tb.sv
